//--- dv/radio_core_checker.sv
/*
 * Bound timing checks for radio_core:
 *   rx and tx strobes two cycles behind their inputs
 *   readback ack one cycle behind its strobe
 */

module radio_core_checker (
   input logic radio_clk,
   input logic i_reset,
   input logic i_rx_stb,
   input logic o_rx_stb,
   input logic i_tx_stb,
   input logic o_tx_stb,
   input logic i_rb_stb,
   input logic o_rb_ack
);

   // rx is correction then substitution
   rx_stb_latency: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_rx_stb == $past(i_rx_stb, 2))
      else $error("o_rx_stb does not follow i_rx_stb by 2 cycles");

   // tx is source select then correction
   tx_stb_latency: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_tx_stb == $past(i_tx_stb, 2))
      else $error("o_tx_stb does not follow i_tx_stb by 2 cycles");

   rb_ack_latency: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_rb_ack == $past(i_rb_stb))  // no ack without a strobe either
      else $error("o_rb_ack not exactly 1 cycle after i_rb_stb");

endmodule

bind radio_core radio_core_checker radio_core_checker_i (
   .radio_clk (radio_clk),
   .i_reset   (i_reset),
   .i_rx_stb  (i_rx_stb),
   .o_rx_stb  (o_rx_stb),
   .i_tx_stb  (i_tx_stb),
   .o_tx_stb  (o_tx_stb),
   .i_rb_stb  (i_rb_stb),
   .o_rb_ack  (o_rb_ack)
);

//--- dv/radio_core_tb.sv
/*
 * Directed testbench for the radio slot:
 *   clock, reset and a Galois LFSR for sample data
 *   compare tasks per result type, register and stream helpers
 *   six directed tests, cycle timeout and closing summary
 */

module radio_core_tb import radio_pkg::*; ();

   localparam set_addr_t SR_BASE = 8'd160;
   localparam set_addr_t RB_BASE = 8'd16;
   localparam int        COMP_W  = 16;
   localparam int        COMP_MAX = (1 << (COMP_W - 1)) - 1;  // +32767
   localparam int        COMP_MIN = -(1 << (COMP_W - 1));     // -32768

   // rough cycle budget per test with extra room for sparse streams
   localparam int LEN_RESET  = 20;
   localparam int LEN_REGS   = 15;
   localparam int LEN_ATR    = 15;
   localparam int LEN_RX_OFS = 120;
   localparam int LEN_TX     = 60;
   localparam int LEN_RX_SUB = 60;
   localparam int TIMEOUT_CYCLES =
      2 * (LEN_RESET + LEN_REGS + LEN_ATR + LEN_RX_OFS + LEN_TX + LEN_RX_SUB);

   logic       radio_clk, i_reset;
   logic       i_set_stb, i_rb_stb, o_rb_ack;
   set_addr_t  i_set_addr, i_rb_addr;
   set_data_t  i_set_data, i_misc_in, o_misc_out;
   rb_data_t   o_rb_data;
   logic       i_rx_running, i_tx_running;
   logic       i_rx_stb, i_tx_stb, o_rx_stb, o_tx_stb;
   sample_t    i_rx_sample, i_tx_sample, i_bb_rx_sample, i_bb_tx_sample;
   sample_t    o_rx_sample, o_tx_sample;
   gpio_word_t i_db_gpio_in, o_db_gpio_out, o_db_gpio_ddr;
   led_t       o_led;

   logic [31:0] lfsr;                      // galois state
   int          cycle_count, error_count, check_count, test_count;
   sample_t     rx_ofs_m, tx_ofs_m;         // offsets as last written
   bit          pos_sat_seen, neg_sat_seen;  // clamp coverage

   radio_core #(.SR_BASE(SR_BASE), .RB_BASE(RB_BASE), .COMP_W(COMP_W)) i_radio_core (.*);

   always #10 radio_clk = ~radio_clk;

   // hard stop if a test never returns
   always @(posedge radio_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, a test did not complete", cycle_count);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // random data and expected values
   // ----------------------------------------------------------------------
   function automatic logic lfsr_bit();
      logic lsb;
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h8020_0003;  // taps 32, 22, 2, 1
      return lsb;
   endfunction

   function automatic logic [31:0] lfsr_word(int nbits);
      logic [31:0] w;
      w = '0;
      for (int k = 0; k < nbits; k++) w = {w[30:0], lfsr_bit()};
      return w;
   endfunction

   // signed add clamped to the component range
   function automatic comp_t clamp_add(comp_t a, comp_t b);
      int s;
      s = int'(a) + int'(b);
      if (s > COMP_MAX) begin
         pos_sat_seen = 1'b1;
         return comp_t'(COMP_MAX);
      end
      if (s < COMP_MIN) begin
         neg_sat_seen = 1'b1;
         return comp_t'(COMP_MIN);
      end
      return comp_t'(s);
   endfunction

   function automatic sample_t offset_sample(sample_t s, sample_t ofs);
      return {clamp_add(s[31:16], ofs[31:16]), clamp_add(s[15:0], ofs[15:0])};  // {I, Q}
   endfunction

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------
   task automatic mismatch(string name, logic [63:0] got, logic [63:0] exp);
      error_count++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
   endtask

   task automatic compare_bit(string name, logic got, logic exp);
      check_count++;
      if (got !== exp) mismatch(name, 64'(got), 64'(exp));
   endtask

   task automatic compare_sample(string name, sample_t got, sample_t exp);
      check_count++;
      if (got !== exp) mismatch(name, 64'(got), 64'(exp));
   endtask

   task automatic compare_gpio(string name, gpio_word_t got, gpio_word_t exp);
      check_count++;
      if (got !== exp) mismatch(name, 64'(got), 64'(exp));
   endtask

   task automatic compare_word(string name, set_data_t got, set_data_t exp);
      check_count++;
      if (got !== exp) mismatch(name, 64'(got), 64'(exp));
   endtask

   task automatic compare_rb(string name, rb_data_t got, rb_data_t exp);
      check_count++;
      if (got !== exp) mismatch(name, got, exp);
   endtask

   task automatic compare_led(string name, led_t got, led_t exp);
      check_count++;
      if (got !== exp) mismatch(name, 64'(got), 64'(exp));
   endtask

   // ----------------------------------------------------------------------
   // bus and stream helpers that start and end just after a rising edge
   // ----------------------------------------------------------------------
   task automatic step_cycle();
      @(posedge radio_clk);
      #1;  // drive point
   endtask

   task automatic do_reset();
      i_reset = 1'b1;
      repeat (3) step_cycle();
      i_reset = 1'b0;
      step_cycle();
   endtask

   task automatic write_reg(set_addr_t ofs, set_data_t data);
      i_set_stb  = 1'b1;
      i_set_addr = SR_BASE + ofs;
      i_set_data = data;
      step_cycle();
      i_set_stb  = 1'b0;  // register live from here on
   endtask

   // ack and data must be there exactly one cycle after the strobe
   task automatic check_read(set_addr_t addr, rb_data_t exp, string name);
      i_rb_stb  = 1'b1;
      i_rb_addr = addr;
      step_cycle();
      i_rb_stb  = 1'b0;
      compare_bit("o_rb_ack", o_rb_ack, 1'b1);
      compare_rb(name, o_rb_data, exp);
   endtask

   // n samples on one path with a strobe every cycle when dense and lfsr gaps otherwise
   task automatic stream_samples(input bit is_tx, input int n, input bit dense);
      sample_t    exp_q[$];
      sample_t    smp;
      logic [1:0] stb_hist;  // [1] = strobe driven two cycles back
      int         sent;
      stb_hist = 2'b00;
      sent     = 0;
      do begin
         step_cycle();
         compare_bit(is_tx ? "o_tx_stb" : "o_rx_stb", is_tx ? o_tx_stb : o_rx_stb,
                     stb_hist[1]);
         if (stb_hist[1])
            compare_sample(is_tx ? "o_tx_sample" : "o_rx_sample",
                           is_tx ? o_tx_sample : o_rx_sample, exp_q.pop_front());
         i_rx_stb = 1'b0;
         i_tx_stb = 1'b0;
         stb_hist = {stb_hist[0], 1'b0};
         if (sent < n && (dense || lfsr_bit())) begin
            smp         = lfsr_word(32);
            stb_hist[0] = 1'b1;
            sent++;
            if (is_tx) begin
               i_tx_stb    = 1'b1;
               i_tx_sample = smp;
               exp_q.push_back(offset_sample(i_tx_running ? i_bb_tx_sample : smp, tx_ofs_m));
            end else begin
               i_rx_stb    = 1'b1;
               i_rx_sample = smp;
               exp_q.push_back(i_rx_running ? i_bb_rx_sample : offset_sample(smp, rx_ofs_m));
            end
         end
      end while (sent < n || stb_hist != 2'b00);
   endtask

   task automatic end_test(string name, int errs_before);
      test_count++;
      if (error_count == errs_before) $display("%s ok", name);
      else $display("%s %0d errors", name, error_count - errs_before);
   endtask

   // ----------------------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------------------
   task automatic test_reset_state();
      compare_bit("o_rx_stb", o_rx_stb, 1'b0);
      compare_bit("o_tx_stb", o_tx_stb, 1'b0);
      compare_bit("o_rb_ack", o_rb_ack, 1'b0);
      compare_gpio("o_db_gpio_out", o_db_gpio_out, '0);
      compare_gpio("o_db_gpio_ddr", o_db_gpio_ddr, '0);
      compare_led("o_led", o_led, '0);
      compare_word("o_misc_out", o_misc_out, '0);
      stream_samples(1'b0, 4, 1'b1);  // samples pass as is with zero offsets
      stream_samples(1'b1, 4, 1'b1);
   endtask

   task automatic test_regs();
      set_data_t misc_a;
      write_reg(SR_MISC_OUT, 32'h5a5a_c3c3);
      compare_word("o_misc_out", o_misc_out, 32'h5a5a_c3c3);
      misc_a       = lfsr_word(32);
      i_misc_in    = misc_a;
      i_db_gpio_in = lfsr_word(32);
      step_cycle();
      i_misc_in = lfsr_word(32);  // changes with the strobe so the old value is expected
      check_read(RB_BASE + RB_MISC_IN, {32'd0, misc_a}, "o_rb_data misc_in");
      check_read(RB_BASE + RB_GPIO_IN, {32'd0, i_db_gpio_in}, "o_rb_data gpio_in");
      check_read(RB_BASE + 8'd9, 64'd0, "o_rb_data unmapped");
   endtask

   task automatic test_atr_gpio();
      gpio_word_t words [4];
      led_t       leds [4];
      logic [1:0] st;  // {tx, rx}
      words = '{32'h1111_0001, 32'h2222_0002, 32'h4444_0004, 32'h8888_0008};
      leds  = '{3'b000, 3'b101, 3'b010, 3'b110};  // {rx, txrx_tx, txrx_rx} per state
      write_reg(SR_GPIO_IDLE, words[0]);
      write_reg(SR_GPIO_RX, words[1]);
      write_reg(SR_GPIO_TX, words[2]);
      write_reg(SR_GPIO_FULL, words[3]);
      write_reg(SR_GPIO_DDR, 32'h0000_ffff);
      for (int k = 0; k < 4; k++) begin
         st           = 2'(k + 1);  // rx, tx, full, back to idle
         i_rx_running = st[0];
         i_tx_running = st[1];
         step_cycle();
         compare_gpio("o_db_gpio_out", o_db_gpio_out, words[st]);
         compare_gpio("o_db_gpio_ddr", o_db_gpio_ddr, 32'h0000_ffff);
         compare_led("o_led", o_led, leds[st]);
      end
      check_read(RB_BASE + RB_GPIO_OUT, {32'd0, words[0]}, "o_rb_data gpio_out");
   endtask

   task automatic test_rx_offset();
      pos_sat_seen = 1'b0;
      neg_sat_seen = 1'b0;
      rx_ofs_m = 32'h012c_fb50;  // I +300, Q -1200
      write_reg(SR_RX_FE_OFS, rx_ofs_m);
      stream_samples(1'b0, 16, 1'b1);
      rx_ofs_m = 32'h7000_9000;  // big enough to clamp both ways
      write_reg(SR_RX_FE_OFS, rx_ofs_m);
      stream_samples(1'b0, 32, 1'b0);
      if (!(pos_sat_seen && neg_sat_seen)) begin
         error_count++;
         $display("receive stream never reached both saturation limits");
      end
   endtask

   task automatic test_tx_path();
      i_bb_tx_sample = lfsr_word(32);
      tx_ofs_m       = 32'h6000_a000;  // I +24576, Q -24576
      write_reg(SR_TX_FE_OFS, tx_ofs_m);
      i_tx_running = 1'b1;
      stream_samples(1'b1, 12, 1'b1);
      i_tx_running = 1'b0;
      stream_samples(1'b1, 12, 1'b0);
   endtask

   task automatic test_rx_subst();
      i_bb_rx_sample = lfsr_word(32);
      rx_ofs_m       = 32'h7fff_8000;  // must not touch substituted samples
      write_reg(SR_RX_FE_OFS, rx_ofs_m);
      i_rx_running = 1'b1;
      stream_samples(1'b0, 12, 1'b1);  // back to back
      stream_samples(1'b0, 12, 1'b0);
      i_rx_running = 1'b0;
   endtask

   initial begin
      int errs;
      radio_clk   = 1'b0;
      lfsr        = 32'hcda2_1ba6;
      cycle_count = 0;
      error_count = 0;
      check_count = 0;
      test_count  = 0;
      rx_ofs_m    = '0;
      tx_ofs_m    = '0;
      i_reset     = 1'b1;
      i_set_stb   = 1'b0;
      i_set_addr  = '0;
      i_set_data  = '0;
      i_rb_stb    = 1'b0;
      i_rb_addr   = '0;
      i_rx_running   = 1'b0;
      i_tx_running   = 1'b0;
      i_rx_stb       = 1'b0;
      i_rx_sample    = '0;
      i_tx_stb       = 1'b0;
      i_tx_sample    = '0;
      i_bb_rx_sample = '0;
      i_bb_tx_sample = '0;
      i_db_gpio_in   = '0;
      i_misc_in      = '0;
      do_reset();
      errs = error_count;
      test_reset_state();
      end_test("reset_state", errs);
      errs = error_count;
      test_regs();
      end_test("regs", errs);
      errs = error_count;
      test_atr_gpio();
      end_test("atr_gpio", errs);
      errs = error_count;
      test_rx_offset();
      end_test("rx_offset", errs);
      errs = error_count;
      test_tx_path();
      end_test("tx_path", errs);
      errs = error_count;
      test_rx_subst();
      end_test("rx_subst", errs);
      $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
               error_count);
      if (error_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- hdl/db_gpio_atr.sv
/*
 * ATR driven daughterboard gpio:
 *   atr state from the rx / tx running flags
 *   registered pin word per state plus direction word
 *   registered radio LEDs
 */

module db_gpio_atr import radio_pkg::*; (
   input  logic       radio_clk,
   input  logic       i_reset,
   input  logic       i_rx_running,
   input  logic       i_tx_running,
   // per state pin words from the settings block
   input  gpio_word_t i_gpio_idle,
   input  gpio_word_t i_gpio_rx,
   input  gpio_word_t i_gpio_tx,
   input  gpio_word_t i_gpio_full,
   input  gpio_word_t i_gpio_ddr,
   // to the pins
   output gpio_word_t o_db_gpio_out,
   output gpio_word_t o_db_gpio_ddr,
   output led_t       o_led
);

   atr_state_t atr_state;

   assign atr_state = atr_state_t'({i_tx_running, i_rx_running});

   // ----------------------------------------------------------------------
   // pin word select, one cycle from a flag change to the pins
   // ----------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
      end else begin
         case (atr_state)
            atr_idle: o_db_gpio_out <= i_gpio_idle;
            atr_rx:   o_db_gpio_out <= i_gpio_rx;
            atr_tx:   o_db_gpio_out <= i_gpio_tx;
            default:  o_db_gpio_out <= i_gpio_full;  // atr_full
         endcase
         o_db_gpio_ddr <= i_gpio_ddr;
      end
   end

   // LEDs follow the same timing as the pins
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_led <= '0;
      end else begin
         o_led <= {i_rx_running,                   // rx
                   i_tx_running,                   // txrx_tx
                   i_rx_running & ~i_tx_running};  // txrx_rx, rx on shared port
      end
   end

endmodule

//--- hdl/db_settings.sv
/*
 * Settings register block for one daughterboard slot:
 *   write decode against SR_BASE into gpio, misc and offset registers
 *   registered misc input, misc output straight from its register
 *   readback mux against RB_BASE with a fixed one cycle ack
 */

module db_settings import radio_pkg::*; #(
   parameter set_addr_t SR_BASE = 8'd160,
   parameter set_addr_t RB_BASE = 8'd16
) (
   input  logic       radio_clk,
   input  logic       i_reset,
   // settings bus
   input  logic       i_set_stb,
   input  set_addr_t  i_set_addr,
   input  set_data_t  i_set_data,
   // readback
   input  logic       i_rb_stb,
   input  set_addr_t  i_rb_addr,
   output logic       o_rb_ack,
   output rb_data_t   o_rb_data,
   // misc and gpio status
   input  set_data_t  i_misc_in,
   output set_data_t  o_misc_out,
   input  gpio_word_t i_db_gpio_in,
   input  gpio_word_t i_db_gpio_out,  // current pin word from the atr block
   // configuration to neighbours
   output gpio_word_t o_gpio_idle,
   output gpio_word_t o_gpio_rx,
   output gpio_word_t o_gpio_tx,
   output gpio_word_t o_gpio_full,
   output gpio_word_t o_gpio_ddr,
   output sample_t    o_rx_ofs,
   output sample_t    o_tx_ofs
);

   // absolute addresses
   localparam set_addr_t A_GPIO_IDLE = SR_BASE + SR_GPIO_IDLE;
   localparam set_addr_t A_GPIO_RX   = SR_BASE + SR_GPIO_RX;
   localparam set_addr_t A_GPIO_TX   = SR_BASE + SR_GPIO_TX;
   localparam set_addr_t A_GPIO_FULL = SR_BASE + SR_GPIO_FULL;
   localparam set_addr_t A_GPIO_DDR  = SR_BASE + SR_GPIO_DDR;
   localparam set_addr_t A_MISC_OUT  = SR_BASE + SR_MISC_OUT;
   localparam set_addr_t A_TX_OFS    = SR_BASE + SR_TX_FE_OFS;
   localparam set_addr_t A_RX_OFS    = SR_BASE + SR_RX_FE_OFS;

   localparam set_addr_t A_RB_MISC_IN  = RB_BASE + RB_MISC_IN;
   localparam set_addr_t A_RB_GPIO_IN  = RB_BASE + RB_GPIO_IN;
   localparam set_addr_t A_RB_GPIO_OUT = RB_BASE + RB_GPIO_OUT;

   set_data_t misc_in_q;  // i_misc_in one cycle late

   // ----------------------------------------------------------------------
   // settings writes, live in the cycle after the strobe
   // ----------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_gpio_idle <= '0;
         o_gpio_rx   <= '0;
         o_gpio_tx   <= '0;
         o_gpio_full <= '0;
         o_gpio_ddr  <= '0;  // all pins inputs out of reset
         o_misc_out  <= '0;
         o_rx_ofs    <= '0;
         o_tx_ofs    <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            A_GPIO_IDLE: o_gpio_idle <= i_set_data;
            A_GPIO_RX:   o_gpio_rx   <= i_set_data;
            A_GPIO_TX:   o_gpio_tx   <= i_set_data;
            A_GPIO_FULL: o_gpio_full <= i_set_data;
            A_GPIO_DDR:  o_gpio_ddr  <= i_set_data;
            A_MISC_OUT:  o_misc_out  <= i_set_data;
            A_TX_OFS:    o_tx_ofs    <= i_set_data;  // {I ofs, Q ofs}
            A_RX_OFS:    o_rx_ofs    <= i_set_data;
            default:     ;                           // not ours, drop it
         endcase
      end
   end

   // misc input retimed every cycle
   always_ff @(posedge radio_clk) begin
      misc_in_q <= i_misc_in;
   end

   // ----------------------------------------------------------------------
   // readback, answered exactly one cycle after i_rb_stb
   // ----------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rb_ack <= 1'b0;
      end else begin
         o_rb_ack <= i_rb_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rb_stb) begin
         case (i_rb_addr)
            A_RB_MISC_IN:  o_rb_data <= {32'd0, misc_in_q};
            A_RB_GPIO_IN:  o_rb_data <= {32'd0, i_db_gpio_in};
            A_RB_GPIO_OUT: o_rb_data <= {32'd0, i_db_gpio_out};
            default:       o_rb_data <= '0;  // unmapped reads as zero
         endcase
      end
   end

endmodule

//--- hdl/fe_dc_offset.sv
/*
 * Front end dc offset stage:
 *   signed I and Q offset add with saturation to COMP_W bits
 *   one register stage, strobe delayed with the data
 */

module fe_dc_offset import radio_pkg::*; #(
   parameter int COMP_W = 16  // saturation width, at most 16
) (
   input  logic    radio_clk,
   input  logic    i_reset,
   input  logic    i_stb,
   input  sample_t i_sample,
   input  sample_t i_offset,
   output logic    o_stb,
   output sample_t o_sample
);

   localparam int SAT_MAX = (1 << (COMP_W - 1)) - 1;
   localparam int SAT_MIN = -(1 << (COMP_W - 1));

   comp_t in_i, in_q;    // split sample
   comp_t ofs_i, ofs_q;  // split offset

   // add with one guard bit, then clamp
   function automatic comp_t add_sat(comp_t a, comp_t b);
      logic signed [16:0] sum;
      sum = {a[15], a} + {b[15], b};
      if (sum > SAT_MAX) begin
         return comp_t'(SAT_MAX);
      end else if (sum < SAT_MIN) begin
         return comp_t'(SAT_MIN);
      end
      return sum[15:0];
   endfunction

   assign in_i  = i_sample[31:16];
   assign in_q  = i_sample[15:0];
   assign ofs_i = i_offset[31:16];
   assign ofs_q = i_offset[15:0];

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_stb <= 1'b0;
      end else begin
         o_stb <= i_stb;
      end
   end

   // sample only moves with its strobe
   always_ff @(posedge radio_clk) begin
      if (i_stb) begin
         o_sample <= {add_sat(in_i, ofs_i), add_sat(in_q, ofs_q)};
      end
   end

endmodule

//--- hdl/radio_core.sv
/*
 * Radio clock slice of one daughterboard slot:
 *   settings and readback block
 *   ATR gpio and LED drive
 *   rx / tx sample paths with dc offset and baseband substitution
 */

module radio_core import radio_pkg::*; #(
   parameter set_addr_t SR_BASE = 8'd160,
   parameter set_addr_t RB_BASE = 8'd16,
   parameter int        COMP_W  = 16
) (
   input  logic       radio_clk,
   input  logic       i_reset,
   // settings bus and readback
   input  logic       i_set_stb,
   input  set_addr_t  i_set_addr,
   input  set_data_t  i_set_data,
   input  logic       i_rb_stb,
   input  set_addr_t  i_rb_addr,
   output logic       o_rb_ack,
   output rb_data_t   o_rb_data,
   // atr flags
   input  logic       i_rx_running,
   input  logic       i_tx_running,
   // sample streams
   input  logic       i_rx_stb,
   input  sample_t    i_rx_sample,
   input  logic       i_tx_stb,
   input  sample_t    i_tx_sample,
   input  sample_t    i_bb_rx_sample,
   input  sample_t    i_bb_tx_sample,
   output logic       o_rx_stb,
   output sample_t    o_rx_sample,
   output logic       o_tx_stb,
   output sample_t    o_tx_sample,
   // pins
   input  gpio_word_t i_db_gpio_in,
   output gpio_word_t o_db_gpio_out,
   output gpio_word_t o_db_gpio_ddr,
   output led_t       o_led,
   input  set_data_t  i_misc_in,
   output set_data_t  o_misc_out
);

   gpio_word_t gpio_idle, gpio_rx, gpio_tx, gpio_full, gpio_ddr;  // atr config
   sample_t    rx_ofs, tx_ofs;                                   // fe config

   db_settings #(.SR_BASE(SR_BASE), .RB_BASE(RB_BASE)) db_settings_i (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .i_rb_stb      (i_rb_stb),
      .i_rb_addr     (i_rb_addr),
      .o_rb_ack      (o_rb_ack),
      .o_rb_data     (o_rb_data),
      .i_misc_in     (i_misc_in),
      .o_misc_out    (o_misc_out),
      .i_db_gpio_in  (i_db_gpio_in),
      .i_db_gpio_out (o_db_gpio_out),  // pin word read back
      .o_gpio_idle   (gpio_idle),
      .o_gpio_rx     (gpio_rx),
      .o_gpio_tx     (gpio_tx),
      .o_gpio_full   (gpio_full),
      .o_gpio_ddr    (gpio_ddr),
      .o_rx_ofs      (rx_ofs),
      .o_tx_ofs      (tx_ofs)
   );

   db_gpio_atr db_gpio_atr_i (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_rx_running  (i_rx_running),
      .i_tx_running  (i_tx_running),
      .i_gpio_idle   (gpio_idle),
      .i_gpio_rx     (gpio_rx),
      .i_gpio_tx     (gpio_tx),
      .i_gpio_full   (gpio_full),
      .i_gpio_ddr    (gpio_ddr),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_led         (o_led)
   );

   radio_stream_path #(.COMP_W(COMP_W)) radio_stream_path_i (
      .radio_clk      (radio_clk),
      .i_reset        (i_reset),
      .i_rx_running   (i_rx_running),
      .i_tx_running   (i_tx_running),
      .i_rx_stb       (i_rx_stb),
      .i_rx_sample    (i_rx_sample),
      .i_tx_stb       (i_tx_stb),
      .i_tx_sample    (i_tx_sample),
      .i_bb_rx_sample (i_bb_rx_sample),
      .i_bb_tx_sample (i_bb_tx_sample),
      .i_rx_ofs       (rx_ofs),
      .i_tx_ofs       (tx_ofs),
      .o_rx_stb       (o_rx_stb),
      .o_rx_sample    (o_rx_sample),
      .o_tx_stb       (o_tx_stb),
      .o_tx_sample    (o_tx_sample)
   );

endmodule

//--- hdl/radio_pkg.sv
/*
 * Shared definitions for one daughterboard radio slot:
 *   sample, component, bus word and GPIO word types
 *   LED vector and ATR state encoding
 *   settings register offsets and readback offsets
 */

package radio_pkg;

   // ----------------------------------------------------------------------
   // data types
   // ----------------------------------------------------------------------
   typedef logic        [31:0] sample_t;    // {I[15:0], Q[15:0]}, both signed
   typedef logic signed [15:0] comp_t;      // one I or Q component
   typedef logic        [7:0]  set_addr_t;  // settings / readback address
   typedef logic        [31:0] set_data_t;  // settings write word
   typedef logic        [63:0] rb_data_t;   // readback word
   typedef logic        [31:0] gpio_word_t; // daughterboard gpio pins
   typedef logic        [2:0]  led_t;       // {rx, txrx_tx, txrx_rx}

   // encoding is {tx_running, rx_running}
   typedef enum logic [1:0] {
      atr_idle = 2'd0,
      atr_rx   = 2'd1,
      atr_tx   = 2'd2,
      atr_full = 2'd3
   } atr_state_t;

   // ----------------------------------------------------------------------
   // settings register offsets, added to SR_BASE
   // ----------------------------------------------------------------------
   localparam set_addr_t SR_GPIO_IDLE = 8'd0;   // gpio word, neither path running
   localparam set_addr_t SR_GPIO_RX   = 8'd1;   // receive only
   localparam set_addr_t SR_GPIO_TX   = 8'd2;   // transmit only
   localparam set_addr_t SR_GPIO_FULL = 8'd3;   // full duplex
   localparam set_addr_t SR_GPIO_DDR  = 8'd4;   // 1 = pin driven by fpga
   localparam set_addr_t SR_MISC_OUT  = 8'd5;
   localparam set_addr_t SR_TX_FE_OFS = 8'd48;  // tx front end dc offset
   localparam set_addr_t SR_RX_FE_OFS = 8'd64;  // rx front end dc offset

   // ----------------------------------------------------------------------
   // readback offsets, added to RB_BASE
   // ----------------------------------------------------------------------
   localparam set_addr_t RB_MISC_IN  = 8'd0;
   localparam set_addr_t RB_GPIO_IN  = 8'd1;
   localparam set_addr_t RB_GPIO_OUT = 8'd2;

endpackage

//--- hdl/radio_stream_path.sv
/*
 * Radio sample paths, two cycles each way:
 *   tx   host / baseband source select, then dc offset
 *   rx   dc offset, then baseband substitution while running
 */

module radio_stream_path import radio_pkg::*; #(
   parameter int COMP_W = 16
) (
   input  logic    radio_clk,
   input  logic    i_reset,
   input  logic    i_rx_running,
   input  logic    i_tx_running,
   // from the adc side and the host
   input  logic    i_rx_stb,
   input  sample_t i_rx_sample,
   input  logic    i_tx_stb,
   input  sample_t i_tx_sample,
   // baseband engine samples
   input  sample_t i_bb_rx_sample,
   input  sample_t i_bb_tx_sample,
   // front end offsets
   input  sample_t i_rx_ofs,
   input  sample_t i_tx_ofs,
   output logic    o_rx_stb,
   output sample_t o_rx_sample,
   output logic    o_tx_stb,
   output sample_t o_tx_sample
);

   logic    tx_sel_stb;     // stage 1 of tx
   sample_t tx_sel_sample;
   logic    rx_fe_stb;      // stage 1 of rx
   sample_t rx_fe_sample;

   // ----------------------------------------------------------------------
   // transmit
   // ----------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         tx_sel_stb <= 1'b0;
      end else begin
         tx_sel_stb <= i_tx_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_tx_stb) begin
         // baseband engine owns the dac while tx runs
         tx_sel_sample <= i_tx_running ? i_bb_tx_sample : i_tx_sample;
      end
   end

   fe_dc_offset #(.COMP_W(COMP_W)) tx_fe_i (
      .radio_clk (radio_clk),
      .i_reset   (i_reset),
      .i_stb     (tx_sel_stb),
      .i_sample  (tx_sel_sample),
      .i_offset  (i_tx_ofs),
      .o_stb     (o_tx_stb),
      .o_sample  (o_tx_sample)
   );

   // ----------------------------------------------------------------------
   // receive
   // ----------------------------------------------------------------------
   fe_dc_offset #(.COMP_W(COMP_W)) rx_fe_i (
      .radio_clk (radio_clk),
      .i_reset   (i_reset),
      .i_stb     (i_rx_stb),
      .i_sample  (i_rx_sample),
      .i_offset  (i_rx_ofs),
      .o_stb     (rx_fe_stb),
      .o_sample  (rx_fe_sample)
   );

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rx_stb <= 1'b0;
      end else begin
         o_rx_stb <= rx_fe_stb;
      end
   end

   // substitution sits after correction, baseband samples go out uncorrected
   always_ff @(posedge radio_clk) begin
      if (rx_fe_stb) begin
         o_rx_sample <= i_rx_running ? i_bb_rx_sample : rx_fe_sample;
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the radio_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module radio_core_tb \
   -f verilog.f \
   -o radio_core_sim

# an assertion stop still leaves the output for the search below
sim_out="$(./obj_dir/radio_core_sim 2>&1)" || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1

//--- verilog.f
hdl/radio_pkg.sv
hdl/fe_dc_offset.sv
hdl/db_settings.sv
hdl/db_gpio_atr.sv
hdl/radio_stream_path.sv
hdl/radio_core.sv
dv/radio_core_checker.sv
dv/radio_core_tb.sv
